/* common/sigmon_event_pkg.sv */
`default_nettype none

package sigmon_event_pkg;

	localparam int SELECT_WIDTH = 8;

	// Monitored input widths
	localparam int PACKET_PORTS = 4;
	localparam int NICA_EVENTS = 16;
	localparam int LOCAL_EVENTS = 12;

	// Bit positions inside packet_sop and packet_eop
	localparam int PORT_NWP2SBU = 0;
	localparam int PORT_SBU2NWP = 1;
	localparam int PORT_CXP2SBU = 2;
	localparam int PORT_SBU2CXP = 3;

	// Constant and single-strobe sources
	localparam logic [SELECT_WIDTH-1:0] NO_EVENT = 8'd0;
	localparam logic [SELECT_WIDTH-1:0] EVENT_TRUE = 8'd1;
	localparam logic [SELECT_WIDTH-1:0] TIMESTAMP_24TOGGLE = 8'd2;
	localparam logic [SELECT_WIDTH-1:0] EVENT_FALSE = 8'd3;

	// Packet strobes, base plus port position
	localparam logic [SELECT_WIDTH-1:0] SOP_BASE = 8'd4;
	localparam logic [SELECT_WIDTH-1:0] EOP_BASE = 8'd8;

	// Vector sources, base plus bit index
	localparam logic [SELECT_WIDTH-1:0] NICA_EVENT_BASE = 8'd16;
	localparam logic [SELECT_WIDTH-1:0] LOCAL_EVENT_BASE = 8'd32;

	localparam logic [SELECT_WIDTH-1:0] SIGMON_ENABLED = 8'd48;

	// Index widths for the vector sources
	localparam int PORT_INDEX_WIDTH = $clog2(PACKET_PORTS);
	localparam int NICA_INDEX_WIDTH = $clog2(NICA_EVENTS);
	localparam int LOCAL_INDEX_WIDTH = $clog2(LOCAL_EVENTS);

endpackage

`default_nettype wire

/* common/sigmon_mode_pkg.sv */
`default_nettype none

package sigmon_mode_pkg;

	localparam int COUNT_WIDTH = 32;
	localparam int SELECT_WORD_WIDTH = 32;

	// Field positions in events_select
	localparam int ENABLE_SELECT_LSB = 0;
	localparam int CLEAR_SELECT_LSB = 8;
	localparam int EVENT_SELECT_LSB = 16;
	localparam int MODE_LSB = 24;
	localparam int MODE_WIDTH = 8;

	// Counting rules; codes 3, 6 and above leave the counter idle
	localparam logic [MODE_WIDTH-1:0] SINGLE_EVENT_COUNT_NOLIMIT = 8'd0;
	localparam logic [MODE_WIDTH-1:0] SINGLE_EVENT_COUNT_LIMIT = 8'd1;
	localparam logic [MODE_WIDTH-1:0] REPEAT_COUNT_LIMIT = 8'd2;
	localparam logic [MODE_WIDTH-1:0] WINDOW_COUNT_LIMIT = 8'd4;
	localparam logic [MODE_WIDTH-1:0] DUAL_EVENTS_LATENCY = 8'd5;

endpackage

`default_nettype wire

/* hdl/sigmon_source_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_source_mux
	import sigmon_event_pkg::*;
(
	input logic [SELECT_WIDTH-1:0] select,
	input logic timestamp_counter_24toggle,
	input logic sigmon_enable_event,
	input logic [PACKET_PORTS-1:0] packet_sop,
	input logic [PACKET_PORTS-1:0] packet_eop,
	input logic [NICA_EVENTS-1:0] nica_events,
	input logic [LOCAL_EVENTS-1:0] count_events,
	output logic strobe
);

	logic [SELECT_WIDTH-1:0] sop_offset;
	logic [SELECT_WIDTH-1:0] eop_offset;
	logic [SELECT_WIDTH-1:0] nica_offset;
	logic [SELECT_WIDTH-1:0] local_offset;

	// Offsets are only used once the range check below has passed
	assign sop_offset = select - SOP_BASE;
	assign eop_offset = select - EOP_BASE;
	assign nica_offset = select - NICA_EVENT_BASE;
	assign local_offset = select - LOCAL_EVENT_BASE;

	always_comb
	begin
		case (select)
			NO_EVENT, EVENT_FALSE:
			begin
				strobe = 1'b0;
			end
			EVENT_TRUE:
			begin
				strobe = 1'b1;
			end
			TIMESTAMP_24TOGGLE:
			begin
				strobe = timestamp_counter_24toggle;
			end
			SIGMON_ENABLED:
			begin
				strobe = sigmon_enable_event;
			end
			default:
			begin
				if (select >= SOP_BASE && select < SOP_BASE + PACKET_PORTS)
					strobe = packet_sop[sop_offset[PORT_INDEX_WIDTH-1:0]];
				else if (select >= EOP_BASE && select < EOP_BASE + PACKET_PORTS)
					strobe = packet_eop[eop_offset[PORT_INDEX_WIDTH-1:0]];
				else if (select >= NICA_EVENT_BASE && select < NICA_EVENT_BASE + NICA_EVENTS)
					strobe = nica_events[nica_offset[NICA_INDEX_WIDTH-1:0]];
				else if (select >= LOCAL_EVENT_BASE &&
					select < LOCAL_EVENT_BASE + LOCAL_EVENTS)
					strobe = count_events[local_offset[LOCAL_INDEX_WIDTH-1:0]];
				else
					// Codes without a source
					strobe = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/sigmon_mode_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_mode_counter
	import sigmon_mode_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic counter_enable,
	input logic enable_in,
	input logic clear_in,
	input logic event_in,
	input logic [MODE_WIDTH-1:0] mode,
	input logic [COUNT_WIDTH-1:0] count_limit,
	output logic [COUNT_WIDTH-1:0] count_out,
	output logic event_out
);

	logic counter_enable_q;
	logic restart;
	logic count_enabled;
	logic done;
	logic [COUNT_WIDTH-1:0] counter;
	logic limit_hit;

	// A zero limit disables the compare
	assign limit_hit = (count_limit != '0) && (counter >= count_limit);

	// Rising edge of counter_enable, registered once more before it acts
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			counter_enable_q <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			counter_enable_q <= counter_enable;
			restart <= counter_enable & ~counter_enable_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || restart)
		begin
			counter <= '0;
			count_enabled <= 1'b0;
			done <= 1'b0;
			event_out <= 1'b0;
		end
		else
		begin
			case (mode)
				SINGLE_EVENT_COUNT_NOLIMIT:
				begin
					if (enable_in)
						count_enabled <= 1'b1;
					if (count_enabled && event_in)
						counter <= counter + 1'b1;
				end
				SINGLE_EVENT_COUNT_LIMIT:
				begin
					// Only the first enable before a hit counts
					if (enable_in && !done)
						count_enabled <= 1'b1;
					if (count_enabled)
					begin
						if (limit_hit)
						begin
							event_out <= 1'b1;
							done <= 1'b1;
							count_enabled <= 1'b0;
						end
						else if (event_in)
						begin
							counter <= counter + 1'b1;
						end
					end
				end
				REPEAT_COUNT_LIMIT:
				begin
					if (enable_in)
						count_enabled <= 1'b1;
					if (count_enabled)
					begin
						if (clear_in)
						begin
							count_enabled <= 1'b0;
						end
						else if (limit_hit)
						begin
							// Keeps counting from zero after the pulse
							event_out <= 1'b1;
							counter <= '0;
						end
						else if (event_in)
						begin
							counter <= counter + 1'b1;
						end
					end
				end
				WINDOW_COUNT_LIMIT, DUAL_EVENTS_LATENCY:
				begin
					if (enable_in)
						count_enabled <= 1'b1;
					if (count_enabled)
					begin
						if (clear_in)
						begin
							count_enabled <= 1'b0;
							// Latency mode restarts the measurement on clear
							if (mode == DUAL_EVENTS_LATENCY)
								counter <= '0;
						end
						else if (limit_hit)
						begin
							event_out <= 1'b1;
							count_enabled <= 1'b0;
							counter <= '0;
						end
						else if (event_in)
						begin
							counter <= counter + 1'b1;
						end
					end
				end
				default:
				begin
					// Idle modes hold all state
					counter <= counter;
				end
			endcase

			// One-cycle pulse
			if (event_out)
				event_out <= 1'b0;
		end
	end

	// Restart leaves the reported count alone
	always_ff @(posedge clk)
	begin
		if (reset)
			count_out <= '0;
		else
			count_out <= counter;
	end

endmodule

`default_nettype wire

/* hdl/sigmon_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_counter
	import sigmon_event_pkg::*;
	import sigmon_mode_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic counter_enable,
	input logic sigmon_enable_event,
	input logic timestamp_counter_24toggle,
	input logic [PACKET_PORTS-1:0] packet_sop,
	input logic [PACKET_PORTS-1:0] packet_eop,
	input logic [NICA_EVENTS-1:0] nica_events,
	input logic [LOCAL_EVENTS-1:0] count_events,
	input logic [SELECT_WORD_WIDTH-1:0] events_select,
	input logic [COUNT_WIDTH-1:0] count_limit,
	output logic [COUNT_WIDTH-1:0] count_out,
	output logic event_out
);

	logic enable_in;
	logic clear_in;
	logic event_in;

	sigmon_source_mux enable_select (
		.select(events_select[ENABLE_SELECT_LSB +: SELECT_WIDTH]),
		.timestamp_counter_24toggle(timestamp_counter_24toggle),
		.sigmon_enable_event(sigmon_enable_event),
		.packet_sop(packet_sop),
		.packet_eop(packet_eop),
		.nica_events(nica_events),
		.count_events(count_events),
		.strobe(enable_in)
	);

	sigmon_source_mux clear_select (
		.select(events_select[CLEAR_SELECT_LSB +: SELECT_WIDTH]),
		.timestamp_counter_24toggle(timestamp_counter_24toggle),
		.sigmon_enable_event(sigmon_enable_event),
		.packet_sop(packet_sop),
		.packet_eop(packet_eop),
		.nica_events(nica_events),
		.count_events(count_events),
		.strobe(clear_in)
	);

	sigmon_source_mux event_select (
		.select(events_select[EVENT_SELECT_LSB +: SELECT_WIDTH]),
		.timestamp_counter_24toggle(timestamp_counter_24toggle),
		.sigmon_enable_event(sigmon_enable_event),
		.packet_sop(packet_sop),
		.packet_eop(packet_eop),
		.nica_events(nica_events),
		.count_events(count_events),
		.strobe(event_in)
	);

	// Mode field sits in the top byte of the select word
	sigmon_mode_counter mode_counter (
		.clk(clk),
		.reset(reset),
		.counter_enable(counter_enable),
		.enable_in(enable_in),
		.clear_in(clear_in),
		.event_in(event_in),
		.mode(events_select[MODE_LSB +: MODE_WIDTH]),
		.count_limit(count_limit),
		.count_out(count_out),
		.event_out(event_out)
	);

endmodule

`default_nettype wire

/* verification/sigmon_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_clock_gen
(
	output logic clk,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Three rising edges see reset, release on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verification/sigmon_counter_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_counter_asserts
	import sigmon_mode_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [SELECT_WORD_WIDTH-1:0] events_select,
	input logic [COUNT_WIDTH-1:0] count_limit,
	input logic [COUNT_WIDTH-1:0] count_out,
	input logic event_out
);

	logic [MODE_WIDTH-1:0] mode;

	assign mode = events_select[MODE_LSB +: MODE_WIDTH];

	// The limit pulse lasts one cycle
	event_out_single_cycle: assert property (
		@(posedge clk) disable iff (reset)
		event_out |=> !event_out
	) else $error("event_out high on two consecutive edges");

	// Reset holds the pulse register low
	event_out_low_in_reset: assert property (
		@(posedge clk)
		reset |=> !event_out
	) else $error("event_out high while reset is active");

	// Single limit mode freezes at the limit
	count_within_limit: assert property (
		@(posedge clk) disable iff (reset)
		(mode == SINGLE_EVENT_COUNT_LIMIT && count_limit != '0) |-> (count_out <= count_limit)
	) else $error("count_out went past count_limit in single limit mode");

endmodule

`default_nettype wire

/* verification/sigmon_counter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sigmon_counter_tb
	import sigmon_event_pkg::*;
	import sigmon_mode_pkg::*;
();

	localparam int NO_CLEAR = 255;
	localparam int RESET_TIMEOUT = 20;

	typedef struct packed {
		logic [MODE_WIDTH-1:0] mode;
		logic [SELECT_WIDTH-1:0] enable_code;
		logic [SELECT_WIDTH-1:0] clear_code;
		logic [SELECT_WIDTH-1:0] event_code;
		logic [SELECT_WIDTH-1:0] drive_code;
		logic [COUNT_WIDTH-1:0] limit;
		logic [7:0] event_count;
		logic [7:0] clear_position;
		logic [COUNT_WIDTH-1:0] expected_count;
		logic [7:0] expected_pulses;
	} test_case_t;

	logic clk;
	logic reset;
	logic counter_enable;
	logic sigmon_enable_event;
	logic timestamp_counter_24toggle;
	logic [PACKET_PORTS-1:0] packet_sop;
	logic [PACKET_PORTS-1:0] packet_eop;
	logic [NICA_EVENTS-1:0] nica_events;
	logic [LOCAL_EVENTS-1:0] count_events;
	logic [SELECT_WORD_WIDTH-1:0] events_select;
	logic [COUNT_WIDTH-1:0] count_limit;
	logic [COUNT_WIDTH-1:0] count_out;
	logic event_out;

	test_case_t cases[$];
	int value_errors = 0;
	int timeout_errors = 0;
	int pulse_total = 0;
	int case_index = -1;
	integer seed;

	sigmon_clock_gen clock_gen (
		.clk(clk),
		.reset(reset)
	);

	sigmon_counter i_sigmon_counter (
		.clk(clk),
		.reset(reset),
		.counter_enable(counter_enable),
		.sigmon_enable_event(sigmon_enable_event),
		.timestamp_counter_24toggle(timestamp_counter_24toggle),
		.packet_sop(packet_sop),
		.packet_eop(packet_eop),
		.nica_events(nica_events),
		.count_events(count_events),
		.events_select(events_select),
		.count_limit(count_limit),
		.count_out(count_out),
		.event_out(event_out)
	);

	bind sigmon_counter sigmon_counter_asserts counter_asserts (
		.clk(clk),
		.reset(reset),
		.events_select(events_select),
		.count_limit(count_limit),
		.count_out(count_out),
		.event_out(event_out)
	);

	// Counted on the rising edge, read by the main process on the falling edge
	always @(posedge clk)
	begin
		if (!reset && event_out)
			pulse_total <= pulse_total + 1;
	end

	function automatic void add_case(input int mode, input int enable_code, input int clear_code,
		input int event_code, input int drive_code, input int limit, input int event_count,
		input int clear_position, input int expected_count, input int expected_pulses);
		test_case_t entry;
		entry.mode = mode[MODE_WIDTH-1:0];
		entry.enable_code = enable_code[SELECT_WIDTH-1:0];
		entry.clear_code = clear_code[SELECT_WIDTH-1:0];
		entry.event_code = event_code[SELECT_WIDTH-1:0];
		entry.drive_code = drive_code[SELECT_WIDTH-1:0];
		entry.limit = limit;
		entry.event_count = event_count[7:0];
		entry.clear_position = clear_position[7:0];
		entry.expected_count = expected_count;
		entry.expected_pulses = expected_pulses[7:0];
		cases.push_back(entry);
	endfunction

	// mode, enable, clear, event select, driven source, limit, N, clear at, count, pulses
	function automatic void build_table();
		add_case(0, 1, 0, 4 + PORT_NWP2SBU, 4 + PORT_NWP2SBU, 0, 5, NO_CLEAR, 5, 0);
		add_case(0, 1, 0, 8 + PORT_SBU2CXP, 8 + PORT_SBU2CXP, 0, 3, NO_CLEAR, 3, 0);
		add_case(0, 1, 0, 16 + 9, 16 + 9, 0, 4, NO_CLEAR, 4, 0);
		add_case(0, 1, 0, 32 + 11, 32 + 11, 0, 6, NO_CLEAR, 6, 0);
		add_case(0, 1, 0, 2, 2, 0, 2, NO_CLEAR, 2, 0);
		add_case(0, 1, 0, 48, 48, 0, 3, NO_CLEAR, 3, 0);
		// Unselected or unmapped sources leave the count at zero
		add_case(0, 1, 0, 16 + 3, 16 + 5, 0, 4, NO_CLEAR, 0, 0);
		add_case(0, 1, 0, 12, 8 + PORT_NWP2SBU, 0, 3, NO_CLEAR, 0, 0);
		add_case(0, 0, 0, 4 + PORT_SBU2CXP, 4 + PORT_SBU2CXP, 0, 3, NO_CLEAR, 0, 0);
		add_case(1, 1, 0, 4 + PORT_CXP2SBU, 4 + PORT_CXP2SBU, 3, 6, NO_CLEAR, 3, 1);
		add_case(2, 1, 0, 32, 32, 3, 7, NO_CLEAR, 1, 2);
		add_case(2, 1, 0, 8 + PORT_SBU2NWP, 8 + PORT_SBU2NWP, 2, 6, NO_CLEAR, 0, 3);
		add_case(4, 48, 16 + 1, 16, 16, 0, 6, 3, 3, 0);
		add_case(5, 48, 8 + 1, 4 + 1, 4 + 1, 0, 5, 2, 0, 0);
		add_case(4, 48, 0, 32 + 5, 32 + 5, 4, 6, NO_CLEAR, 0, 1);
		add_case(0, 1, 0, 8 + PORT_NWP2SBU, 8 + PORT_NWP2SBU, 0, 4, NO_CLEAR, 4, 0);
	endfunction

	// Sets the monitored input that a source code stands for
	function automatic void drive_source(input int code, input logic level);
		if (code == int'(TIMESTAMP_24TOGGLE))
			timestamp_counter_24toggle = level;
		else if (code == int'(SIGMON_ENABLED))
			sigmon_enable_event = level;
		else if (code >= int'(SOP_BASE) && code < int'(SOP_BASE) + PACKET_PORTS)
			packet_sop[code - int'(SOP_BASE)] = level;
		else if (code >= int'(EOP_BASE) && code < int'(EOP_BASE) + PACKET_PORTS)
			packet_eop[code - int'(EOP_BASE)] = level;
		else if (code >= int'(NICA_EVENT_BASE) && code < int'(NICA_EVENT_BASE) + NICA_EVENTS)
			nica_events[code - int'(NICA_EVENT_BASE)] = level;
		else if (code >= int'(LOCAL_EVENT_BASE) && code < int'(LOCAL_EVENT_BASE) + LOCAL_EVENTS)
			count_events[code - int'(LOCAL_EVENT_BASE)] = level;
	endfunction

	task automatic wait_cycles(input int cycles);
		for (int i = 0; i < cycles; i++)
			@(negedge clk);
	endtask

	task automatic pulse_source(input int code);
		drive_source(code, 1'b1);
		@(negedge clk);
		drive_source(code, 1'b0);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset && cycles < RESET_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (reset)
		begin
			$display("Timeout: reset still active after %0d cycles", RESET_TIMEOUT);
			timeout_errors++;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] case %0d %s: got 0x%h, expected 0x%h", case_index, name, actual,
				expected);
			value_errors++;
		end
	endtask

	// A counter_enable edge clears the counter, count_out follows
	task automatic restart_monitor();
		counter_enable = 1'b1;
		@(negedge clk);
		counter_enable = 1'b0;
		wait_cycles(4);
		check_value("count_out after restart", count_out, 32'd0);
	endtask

	task automatic run_case(input test_case_t entry);
		int gap;
		int pulse_start;
		events_select[MODE_LSB +: MODE_WIDTH] = entry.mode;
		events_select[ENABLE_SELECT_LSB +: SELECT_WIDTH] = entry.enable_code;
		events_select[CLEAR_SELECT_LSB +: SELECT_WIDTH] = entry.clear_code;
		events_select[EVENT_SELECT_LSB +: SELECT_WIDTH] = entry.event_code;
		count_limit = entry.limit;
		// Restart starts the monitor on the new selection
		restart_monitor();
		// Strobed enable sources get a single pulse
		if (entry.enable_code != EVENT_TRUE)
		begin
			pulse_source(int'(entry.enable_code));
			wait_cycles(2);
		end
		pulse_start = pulse_total;
		for (int i = 0; i < int'(entry.event_count); i++)
		begin
			if (i == int'(entry.clear_position))
			begin
				pulse_source(int'(entry.clear_code));
				wait_cycles(2);
			end
			pulse_source(int'(entry.drive_code));
			gap = 2 + int'($unsigned($random(seed)) % 3);
			wait_cycles(gap);
		end
		wait_cycles(4);
		check_value("count_out", count_out, entry.expected_count);
		check_value("event_out pulses", pulse_total - pulse_start, 32'(entry.expected_pulses));
	endtask

	initial
	begin : main
		counter_enable = 1'b0;
		sigmon_enable_event = 1'b0;
		timestamp_counter_24toggle = 1'b0;
		packet_sop = '0;
		packet_eop = '0;
		nica_events = '0;
		count_events = '0;
		events_select = '0;
		count_limit = '0;
		seed = 24;
		build_table();

		wait_reset_release();
		check_value("count_out after reset", count_out, 32'd0);
		check_value("event_out after reset", {31'd0, event_out}, 32'd0);

		foreach (cases[i])
		begin
			case_index = i;
			run_case(cases[i]);
		end

		case_index = cases.size();
		restart_monitor();

		$display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
common/sigmon_event_pkg.sv
common/sigmon_mode_pkg.sv
hdl/sigmon_source_mux.sv
hdl/sigmon_mode_counter.sv
hdl/sigmon_counter.sv
verification/sigmon_clock_gen.sv
verification/sigmon_counter_asserts.sv
verification/sigmon_counter_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= sigmon_counter_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
EXTRA_FLAGS ?= -Wno-fatal
PASS_TEXT ?= All tests passed

BASE_FLAGS := --binary --timing --assert
SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(BASE_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILE_LIST)

run: $(SIM)
	@output="$$($(SIM))"; echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
